// File: hdl/lane_seq_pkg.sv
// Lane sequencer shared types
`default_nettype none

package lane_seq_pkg;

  ////////////////////////////////////////////////////
  // Sizes and register indices
  ////////////////////////////////////////////////////

  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned NrOpQueues = 7;
  localparam int unsigned VlWidth    = 16;
  localparam int unsigned VregWidth  = 5;

  // The mask always lives in v0
  localparam logic [VregWidth-1:0] VMASK = '0;

  // Operand queue indices, MaskM is the last one
  localparam int unsigned AluA    = 0;
  localparam int unsigned AluB    = 1;
  localparam int unsigned MulFpuA = 2;
  localparam int unsigned MulFpuB = 3;
  localparam int unsigned MulFpuC = 4;
  localparam int unsigned StA     = 5;
  localparam int unsigned MaskM   = 6;

  ////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  typedef enum logic [1:0] {VFU_None, VFU_Alu, VFU_MFpu, VFU_StoreUnit} vfu_e;
  typedef enum logic [2:0] {VADD, VMUL, VFMACC, VREDSUM, VSE} op_e;
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  // Request from the main sequencer
  typedef struct packed {
    vid_t                 id;
    op_e                  op;
    vfu_e                 vfu;
    logic                 vm;
    logic [VregWidth-1:0] vs1;
    logic [VregWidth-1:0] vs2;
    logic [VregWidth-1:0] vd;
    logic                 use_vs1;
    logic                 use_vs2;
    logic                 use_vd_op;
    logic                 swap_vs2_vd_op;
    vew_e                 eew_vs1;
    vew_e                 eew_vs2;
    vew_e                 eew_vd_op;
    vew_e                 vsew;
    logic [VlWidth-1:0]   vl;
    logic [VlWidth-1:0]   vstart;
    logic [NrVInsn-1:0]   hazard_vs1;
    logic [NrVInsn-1:0]   hazard_vs2;
    logic [NrVInsn-1:0]   hazard_vd;
    logic [NrVInsn-1:0]   hazard_vm;
  } pe_req_t;

  // Command toward the operand requester
  typedef struct packed {
    vid_t                 id;
    logic [VregWidth-1:0] vs;
    vew_e                 eew;
    logic [VlWidth-1:0]   vl;
    logic [VlWidth-1:0]   vstart;
    logic [NrVInsn-1:0]   hazard;
    logic                 zext_neutral;
  } opreq_cmd_t;

  // Lane-local operation for the functional units
  typedef struct packed {
    vid_t                 id;
    op_e                  op;
    vfu_e                 vfu;
    logic                 vm;
    logic [VregWidth-1:0] vd;
    vew_e                 vsew;
    logic [VlWidth-1:0]   vl;
    logic [VlWidth-1:0]   vstart;
  } vfu_op_t;

  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;
  } pe_resp_t;

  typedef struct packed {
    logic [VlWidth-1:0] vl_lane;
    logic [VlWidth-1:0] vstart_lane;
    logic               muted;
  } lane_len_t;

endpackage

`default_nettype wire

// File: hdl/pe_req_register.sv
// Request fall-through register
`timescale 1ns/1ps
`default_nettype none

module pe_req_register import lane_seq_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pe_req_t req_i,
  input  logic    valid_i,
  output logic    ready_o,
  output pe_req_t req_o,
  output logic    valid_o,
  input  logic    ready_i
);

  pe_req_t data_q;
  logic    full_q;

  // An empty register shows the incoming request directly
  assign valid_o = full_q | valid_i;
  assign req_o   = full_q ? data_q : req_i;
  assign ready_o = ~full_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= ~ready_i | valid_i;
    end else begin
      full_q <= valid_i & ~ready_i;
    end
  end

  // Storing a request that passes straight through is harmless
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= req_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(req_o))
    else $error("Pending request changed before it was taken");

endmodule

`default_nettype wire

// File: hdl/lane_vl_split.sv
// Per-lane length split
`timescale 1ns/1ps
`default_nettype none

module lane_vl_split import lane_seq_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  localparam int unsigned LaneIdWidth = $clog2(NrLanes)
) (
  input  logic [LaneIdWidth-1:0] lane_id_i,
  input  pe_req_t                req_i,
  output lane_len_t              len_o
);

  logic [VlWidth-1:0] vl_lane;
  logic [VlWidth-1:0] vstart_lane;
  logic               lane_fu;

  // Elements are interleaved, so the low lanes take the remainder
  assign vl_lane = (req_i.vl >> LaneIdWidth) +
                   VlWidth'(lane_id_i < req_i.vl[LaneIdWidth-1:0]);

  assign vstart_lane = (req_i.vstart >> LaneIdWidth) +
                       VlWidth'(lane_id_i < req_i.vstart[LaneIdWidth-1:0]);

  // Only the in-lane units can skip an instruction
  assign lane_fu = (req_i.vfu == VFU_Alu) || (req_i.vfu == VFU_MFpu);

  // Reductions need every lane to take part, even an empty one
  always_comb begin
    len_o.vl_lane     = vl_lane;
    len_o.vstart_lane = vstart_lane;
    len_o.muted       = (vl_lane == '0) && lane_fu && (req_i.op != VREDSUM);
  end

endmodule

`default_nettype wire

// File: hdl/opreq_builder.sv
// Operand request command builder
`timescale 1ns/1ps
`default_nettype none

module opreq_builder import lane_seq_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  localparam int unsigned LaneIdWidth = $clog2(NrLanes)
) (
  input  pe_req_t                     req_i,
  input  lane_len_t                   len_i,
  output opreq_cmd_t [NrOpQueues-1:0] cmd_o,
  output logic       [NrOpQueues-1:0] push_o
);

  // Divide by a power of two, rounding up
  function automatic logic [VlWidth-1:0] ceil_shr(logic [VlWidth-1:0] val, int unsigned sh);
    logic [VlWidth-1:0] rem_mask;
    rem_mask = ~({VlWidth{1'b1}} << sh);
    return (val >> sh) + VlWidth'(|(val & rem_mask));
  endfunction

  function automatic opreq_cmd_t make_cmd(opreq_cmd_t base, logic [VregWidth-1:0] vs,
                                          vew_e eew, logic [VlWidth-1:0] vl,
                                          logic [NrVInsn-1:0] hazard);
    opreq_cmd_t cmd;
    cmd        = base;
    cmd.vs     = vs;
    cmd.eew    = eew;
    cmd.vl     = vl;
    cmd.hazard = hazard;
    return cmd;
  endfunction

  always_comb begin
    opreq_cmd_t         base;
    logic               redsum;
    logic               lane_empty;
    logic               swap;
    logic [NrVInsn-1:0] hz_vs1;
    logic [NrVInsn-1:0] hz_vs2;
    logic [VlWidth-1:0] vl_mask;

    base        = '0;
    base.id     = req_i.id;
    base.vstart = len_i.vstart_lane;

    redsum     = (req_i.op == VREDSUM);
    lane_empty = (len_i.vl_lane == '0);
    swap       = req_i.swap_vs2_vd_op;
    hz_vs1     = req_i.hazard_vs1 | req_i.hazard_vd;
    hz_vs2     = req_i.hazard_vs2 | req_i.hazard_vd;

    // One mask bit per element, packed across all lanes
    vl_mask = ceil_shr(req_i.vl, 3 + LaneIdWidth + int'(req_i.vsew));

    cmd_o  = '0;
    push_o = '0;

    unique case (req_i.vfu)
      VFU_Alu: begin
        // The scalar accumulator of a reduction sits in AluA
        cmd_o[AluA] = make_cmd(base, req_i.vs1, req_i.eew_vs1,
                               redsum ? VlWidth'(1) : len_i.vl_lane, hz_vs1);
        cmd_o[AluB] = make_cmd(base, req_i.vs2, req_i.eew_vs2,
                               (redsum && lane_empty) ? VlWidth'(1) : len_i.vl_lane, hz_vs2);
        // An empty lane feeds the reduction with neutral values
        cmd_o[AluA].zext_neutral = lane_empty;
        cmd_o[AluB].zext_neutral = lane_empty;
        push_o[AluA] = req_i.use_vs1;
        push_o[AluB] = req_i.use_vs2;
      end
      VFU_MFpu: begin
        cmd_o[MulFpuA] = make_cmd(base, req_i.vs1, req_i.eew_vs1, len_i.vl_lane, hz_vs1);
        if (swap) begin
          cmd_o[MulFpuB] = make_cmd(base, req_i.vd, req_i.eew_vd_op, len_i.vl_lane,
                                    req_i.hazard_vd);
          cmd_o[MulFpuC] = make_cmd(base, req_i.vs2, req_i.eew_vs2, len_i.vl_lane, hz_vs2);
        end else begin
          cmd_o[MulFpuB] = make_cmd(base, req_i.vs2, req_i.eew_vs2, len_i.vl_lane, hz_vs2);
          cmd_o[MulFpuC] = make_cmd(base, req_i.vd, req_i.eew_vd_op, len_i.vl_lane,
                                    req_i.hazard_vd);
        end
        push_o[MulFpuA] = req_i.use_vs1;
        push_o[MulFpuB] = swap ? req_i.use_vd_op : req_i.use_vs2;
        push_o[MulFpuC] = swap ? req_i.use_vs2 : req_i.use_vd_op;
      end
      VFU_StoreUnit: begin
        // The store unit collects from all lanes, so every lane sends the rounded-up share
        cmd_o[StA]  = make_cmd(base, req_i.vs1, req_i.eew_vs1,
                               ceil_shr(req_i.vl, LaneIdWidth), hz_vs1);
        push_o[StA] = req_i.use_vs1;
      end
      default: ;
    endcase

    if (req_i.vfu != VFU_None) begin
      cmd_o[MaskM]  = make_cmd(base, VMASK, req_i.vsew, vl_mask,
                               req_i.hazard_vm | req_i.hazard_vd);
      push_o[MaskM] = ~req_i.vm;
    end

    // A skipped instruction needs no operands at all
    if (len_i.muted) begin
      push_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/opreq_slots.sv
// Operand request slots
`timescale 1ns/1ps
`default_nettype none

module opreq_slots import lane_seq_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  opreq_cmd_t [NrOpQueues-1:0] cmd_i,
  input  logic       [NrOpQueues-1:0] push_i,
  output opreq_cmd_t [NrOpQueues-1:0] cmd_o,
  output logic       [NrOpQueues-1:0] valid_o,
  input  logic       [NrOpQueues-1:0] ready_i
);

  // A slot drains on ready and refills on push, the push taking priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      valid_o <= push_i | (valid_o & ~ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOpQueues; q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end
    end
  end

  // The issue logic only pushes into slots it found free
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i & valid_o & ~ready_i) == '0)
    else $error("Operand request pushed into an occupied slot");

endmodule

`default_nettype wire

// File: hdl/issue_ctrl.sv
// Issue control
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pe_req_t               req_i,
  input  logic                  valid_i,
  input  lane_len_t             len_i,
  input  logic [NrOpQueues-1:0] slot_busy_i,
  input  logic [NrVInsn-1:0]    running_i,
  output logic                  accept_o,
  output vfu_op_t               vfu_op_o,
  output logic                  vfu_op_valid_o
);

  logic [NrOpQueues-1:0] used_slots;

  // Slots that the request's unit could push into
  always_comb begin
    used_slots = '0;
    unique case (req_i.vfu)
      VFU_Alu: begin
        used_slots[AluA]  = 1'b1;
        used_slots[AluB]  = 1'b1;
        used_slots[MaskM] = 1'b1;
      end
      VFU_MFpu: begin
        used_slots[MulFpuA] = 1'b1;
        used_slots[MulFpuB] = 1'b1;
        used_slots[MulFpuC] = 1'b1;
        used_slots[MaskM]   = 1'b1;
      end
      VFU_StoreUnit: begin
        used_slots[StA]   = 1'b1;
        used_slots[MaskM] = 1'b1;
      end
      default: ;
    endcase
  end

  // A request whose ID is still live waits in the register
  assign accept_o = valid_i && !running_i[req_i.id] && ((slot_busy_i & used_slots) == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_op_valid_o <= 1'b0;
    end else begin
      vfu_op_valid_o <= accept_o & ~len_i.muted;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      vfu_op_o.id     <= req_i.id;
      vfu_op_o.op     <= req_i.op;
      vfu_op_o.vfu    <= req_i.vfu;
      vfu_op_o.vm     <= req_i.vm;
      vfu_op_o.vd     <= req_i.vd;
      vfu_op_o.vsew   <= req_i.vsew;
      vfu_op_o.vl     <= len_i.vl_lane;
      vfu_op_o.vstart <= len_i.vstart_lane;
    end
  end

endmodule

`default_nettype wire

// File: hdl/insn_tracker.sv
// Instruction ID tracker
`timescale 1ns/1ps
`default_nettype none

module insn_tracker import lane_seq_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NrVInsn-1:0] pe_running_i,
  input  logic               accept_i,
  input  vid_t               accept_id_i,
  input  logic               muted_i,
  input  logic [NrVInsn-1:0] alu_done_i,
  input  logic [NrVInsn-1:0] mfpu_done_i,
  output logic [NrVInsn-1:0] running_o,
  output pe_resp_t           resp_o,
  output logic               alu_done_o,
  output logic               mfpu_done_o
);

  logic [NrVInsn-1:0] running_q;
  logic [NrVInsn-1:0] done_q;
  logic [NrVInsn-1:0] accept_oh;

  assign accept_oh = accept_i ? (NrVInsn'(1) << accept_id_i) : '0;

  // The main sequencer retires IDs by dropping them from its running set
  assign running_o = running_q & pe_running_i;

  assign resp_o.vinsn_done = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q   <= '0;
      done_q      <= '0;
      alu_done_o  <= 1'b0;
      mfpu_done_o <= 1'b0;
    end else begin
      running_q   <= running_o | accept_oh;
      // A muted instruction is finished as soon as it is accepted
      done_q      <= alu_done_i | mfpu_done_i | (muted_i ? accept_oh : '0);
      alu_done_o  <= |alu_done_i;
      mfpu_done_o <= |mfpu_done_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lane_sequencer.sv
// Lane sequencer issue stage
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer import lane_seq_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  localparam int unsigned LaneIdWidth = $clog2(NrLanes)
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic       [LaneIdWidth-1:0] lane_id_i,
  // Main sequencer side
  input  pe_req_t                     pe_req_i,
  input  logic                        pe_req_valid_i,
  input  logic       [NrVInsn-1:0]    pe_vinsn_running_i,
  output logic                        pe_req_ready_o,
  output pe_resp_t                    pe_resp_o,
  // Operand requester side
  output opreq_cmd_t [NrOpQueues-1:0] operand_request_o,
  output logic       [NrOpQueues-1:0] operand_request_valid_o,
  input  logic       [NrOpQueues-1:0] operand_request_ready_i,
  output logic                        alu_vinsn_done_o,
  output logic                        mfpu_vinsn_done_o,
  // Functional unit side, the ready inputs are not needed for issue
  output vfu_op_t                     vfu_operation_o,
  output logic                        vfu_operation_valid_o,
  input  logic                        alu_ready_i,
  input  logic       [NrVInsn-1:0]    alu_vinsn_done_i,
  input  logic                        mfpu_ready_i,
  input  logic       [NrVInsn-1:0]    mfpu_vinsn_done_i
);

  if (NrLanes < 2 || NrLanes > 8 || (NrLanes & (NrLanes - 1)) != 0) begin : gen_lanes_check
    $error("NrLanes must be a power of two from 2 to 8");
  end

  pe_req_t                     req;
  logic                        req_valid;
  logic                        accept;
  lane_len_t                   len;
  opreq_cmd_t [NrOpQueues-1:0] build_cmd;
  logic       [NrOpQueues-1:0] build_push;
  logic       [NrOpQueues-1:0] slot_push;
  logic       [NrVInsn-1:0]    running;

  ////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////

  pe_req_register i_req_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (pe_req_i),
    .valid_i (pe_req_valid_i),
    .ready_o (pe_req_ready_o),
    .req_o   (req),
    .valid_o (req_valid),
    .ready_i (accept)
  );

  lane_vl_split #(
    .NrLanes (NrLanes)
  ) i_vl_split (
    .lane_id_i (lane_id_i),
    .req_i     (req),
    .len_o     (len)
  );

  ////////////////////////////////////////////////////
  // Operand requests
  ////////////////////////////////////////////////////

  opreq_builder #(
    .NrLanes (NrLanes)
  ) i_builder (
    .req_i  (req),
    .len_i  (len),
    .cmd_o  (build_cmd),
    .push_o (build_push)
  );

  // Slots only load on the accepting edge
  assign slot_push = build_push & {NrOpQueues{accept}};

  opreq_slots i_slots (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (build_cmd),
    .push_i  (slot_push),
    .cmd_o   (operand_request_o),
    .valid_o (operand_request_valid_o),
    .ready_i (operand_request_ready_i)
  );

  ////////////////////////////////////////////////////
  // Issue and bookkeeping
  ////////////////////////////////////////////////////

  issue_ctrl i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req),
    .valid_i        (req_valid),
    .len_i          (len),
    .slot_busy_i    (operand_request_valid_o),
    .running_i      (running),
    .accept_o       (accept),
    .vfu_op_o       (vfu_operation_o),
    .vfu_op_valid_o (vfu_operation_valid_o)
  );

  insn_tracker i_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pe_running_i (pe_vinsn_running_i),
    .accept_i     (accept),
    .accept_id_i  (req.id),
    .muted_i      (len.muted),
    .alu_done_i   (alu_vinsn_done_i),
    .mfpu_done_i  (mfpu_vinsn_done_i),
    .running_o    (running),
    .resp_o       (pe_resp_o),
    .alu_done_o   (alu_vinsn_done_o),
    .mfpu_done_o  (mfpu_vinsn_done_o)
  );

endmodule

`default_nettype wire

// File: test/tb_lane_sequencer.sv
// Lane sequencer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lane_sequencer import lane_seq_pkg::*; ();

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned LaneIdWidth = $clog2(NrLanes);
  localparam int          ClkPeriod   = 10;
  localparam int          NumTests    = 6;
  localparam int          MaxWait     = 50;

  // Everything the lane should show one cycle after an accept
  typedef struct packed {
    vfu_op_t                     op;
    logic                        muted;
    logic       [NrOpQueues-1:0] push;
    opreq_cmd_t [NrOpQueues-1:0] cmd;
  } expect_t;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic       [LaneIdWidth-1:0] lane_id;
  pe_req_t                     pe_req;
  logic                        pe_req_valid;
  logic       [NrVInsn-1:0]    pe_running;
  logic                        pe_req_ready;
  pe_resp_t                    pe_resp;
  opreq_cmd_t [NrOpQueues-1:0] opreq;
  logic       [NrOpQueues-1:0] opreq_valid;
  logic       [NrOpQueues-1:0] opreq_ready;
  logic                        alu_done;
  logic                        mfpu_done;
  vfu_op_t                     vfu_op;
  logic                        vfu_op_valid;
  logic                        alu_ready;
  logic       [NrVInsn-1:0]    alu_done_in;
  logic                        mfpu_ready;
  logic       [NrVInsn-1:0]    mfpu_done_in;

  expect_t expected;
  logic    check_armed;
  int      errors;
  int      checks;
  int      tests_run;
  int      err_mark;

  always #(ClkPeriod / 2) clk = ~clk;

  lane_sequencer #(
    .NrLanes (NrLanes)
  ) dut (
    .clk_i                   (clk),
    .rst_ni                  (rst_n),
    .lane_id_i               (lane_id),
    .pe_req_i                (pe_req),
    .pe_req_valid_i          (pe_req_valid),
    .pe_vinsn_running_i      (pe_running),
    .pe_req_ready_o          (pe_req_ready),
    .pe_resp_o               (pe_resp),
    .operand_request_o       (opreq),
    .operand_request_valid_o (opreq_valid),
    .operand_request_ready_i (opreq_ready),
    .alu_vinsn_done_o        (alu_done),
    .mfpu_vinsn_done_o       (mfpu_done),
    .vfu_operation_o         (vfu_op),
    .vfu_operation_valid_o   (vfu_op_valid),
    .alu_ready_i             (alu_ready),
    .alu_vinsn_done_i        (alu_done_in),
    .mfpu_ready_i            (mfpu_ready),
    .mfpu_vinsn_done_i       (mfpu_done_in)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic opreq_cmd_t operand_cmd(opreq_cmd_t base, logic [VregWidth-1:0] vs,
                                             vew_e eew, int unsigned vl,
                                             logic [NrVInsn-1:0] hazard);
    opreq_cmd_t c;
    c        = base;
    c.vs     = vs;
    c.eew    = eew;
    c.vl     = VlWidth'(vl);
    c.hazard = hazard;
    return c;
  endfunction

  function automatic expect_t ref_model(pe_req_t r, int unsigned lane);
    expect_t            e;
    opreq_cmd_t         base;
    int unsigned        vl_lane;
    int unsigned        vstart_lane;
    int unsigned        mask_div;
    logic               redsum;
    logic [NrVInsn-1:0] hz1;
    logic [NrVInsn-1:0] hz2;
    e           = '0;
    vl_lane     = r.vl / NrLanes + ((lane < r.vl % NrLanes) ? 1 : 0);
    vstart_lane = r.vstart / NrLanes + ((lane < r.vstart % NrLanes) ? 1 : 0);
    redsum      = (r.op == VREDSUM);
    e.muted     = (vl_lane == 0) && (r.vfu == VFU_Alu || r.vfu == VFU_MFpu) && !redsum;

    e.op.id     = r.id;
    e.op.op     = r.op;
    e.op.vfu    = r.vfu;
    e.op.vm     = r.vm;
    e.op.vd     = r.vd;
    e.op.vsew   = r.vsew;
    e.op.vl     = VlWidth'(vl_lane);
    e.op.vstart = VlWidth'(vstart_lane);

    base        = '0;
    base.id     = r.id;
    base.vstart = VlWidth'(vstart_lane);
    hz1         = r.hazard_vs1 | r.hazard_vd;
    hz2         = r.hazard_vs2 | r.hazard_vd;

    case (r.vfu)
      VFU_Alu: begin
        e.cmd[AluA] = operand_cmd(base, r.vs1, r.eew_vs1, redsum ? 1 : vl_lane, hz1);
        e.cmd[AluB] = operand_cmd(base, r.vs2, r.eew_vs2,
                                  (redsum && vl_lane == 0) ? 1 : vl_lane, hz2);
        e.cmd[AluA].zext_neutral = (vl_lane == 0);
        e.cmd[AluB].zext_neutral = (vl_lane == 0);
        e.push[AluA] = r.use_vs1;
        e.push[AluB] = r.use_vs2;
      end
      VFU_MFpu: begin
        e.cmd[MulFpuA]  = operand_cmd(base, r.vs1, r.eew_vs1, vl_lane, hz1);
        e.push[MulFpuA] = r.use_vs1;
        if (r.swap_vs2_vd_op) begin
          e.cmd[MulFpuB]  = operand_cmd(base, r.vd, r.eew_vd_op, vl_lane, r.hazard_vd);
          e.cmd[MulFpuC]  = operand_cmd(base, r.vs2, r.eew_vs2, vl_lane, hz2);
          e.push[MulFpuB] = r.use_vd_op;
          e.push[MulFpuC] = r.use_vs2;
        end else begin
          e.cmd[MulFpuB]  = operand_cmd(base, r.vs2, r.eew_vs2, vl_lane, hz2);
          e.cmd[MulFpuC]  = operand_cmd(base, r.vd, r.eew_vd_op, vl_lane, r.hazard_vd);
          e.push[MulFpuB] = r.use_vs2;
          e.push[MulFpuC] = r.use_vd_op;
        end
      end
      VFU_StoreUnit: begin
        e.cmd[StA]  = operand_cmd(base, r.vs1, r.eew_vs1, (r.vl + NrLanes - 1) / NrLanes, hz1);
        e.push[StA] = r.use_vs1;
      end
      default: ;
    endcase

    if (r.vfu != VFU_None) begin
      // One mask bit per element across all lanes, packed into vsew-wide words
      mask_div       = 8 * NrLanes * (2 ** int'(r.vsew));
      e.cmd[MaskM]   = operand_cmd(base, VMASK, r.vsew, (r.vl + mask_div - 1) / mask_div,
                                   r.hazard_vm | r.hazard_vd);
      e.push[MaskM]  = !r.vm;
    end
    if (e.muted) begin
      e.push = '0;
    end
    return e;
  endfunction

  function automatic pe_req_t rand_req(vid_t id, op_e op, vfu_e vfu, int unsigned vl);
    pe_req_t r;
    r                = '0;
    r.id             = id;
    r.op             = op;
    r.vfu            = vfu;
    r.vs1            = VregWidth'($urandom_range(1, 31));
    r.vs2            = VregWidth'($urandom_range(1, 31));
    r.vd             = VregWidth'($urandom_range(1, 31));
    r.use_vs1        = 1'b1;
    r.use_vs2        = 1'b1;
    r.use_vd_op      = 1'b1;
    r.eew_vs1        = vew_e'($urandom_range(0, 3));
    r.eew_vs2        = vew_e'($urandom_range(0, 3));
    r.eew_vd_op      = vew_e'($urandom_range(0, 3));
    r.vsew           = vew_e'($urandom_range(0, 3));
    r.vl             = VlWidth'(vl);
    r.vstart         = VlWidth'($urandom_range(0, vl));
    r.hazard_vs1     = NrVInsn'($urandom);
    r.hazard_vs2     = NrVInsn'($urandom);
    r.hazard_vd      = NrVInsn'($urandom);
    r.hazard_vm      = NrVInsn'($urandom);
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  // Compares the lane outputs on the falling edge after an accept
  always @(negedge clk) begin
    if (check_armed) begin
      check_value("vfu_operation_valid_o", 64'(vfu_op_valid), 64'(!expected.muted));
      if (!expected.muted) begin
        check_value("vfu_operation_o", 64'(vfu_op), 64'(expected.op));
      end
      check_value("operand_request_valid_o", 64'(opreq_valid), 64'(expected.push));
      for (int unsigned q = 0; q < NrOpQueues; q++) begin
        if (expected.push[q]) begin
          check_value($sformatf("operand_request_o[%0d]", q), 64'(opreq[q]),
                      64'(expected.cmd[q]));
        end
      end
      check_value("pe_resp_o.vinsn_done", 64'(pe_resp.vinsn_done),
                  expected.muted ? (64'(1) << expected.op.id) : 64'(0));
      check_armed = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Returns at the rising edge where the request transfers
  task automatic send_req(pe_req_t r, int unsigned lane, output bit taken);
    int n;
    n = 0;
    @(negedge clk);
    lane_id      = LaneIdWidth'(lane);
    pe_req       = r;
    pe_req_valid = 1'b1;
    @(posedge clk);
    while (!pe_req_ready && n < MaxWait) begin
      n++;
      @(posedge clk);
    end
    taken = pe_req_ready;
    if (!taken) begin
      errors++;
      $display("Request with id %0d was never taken by the lane", r.id);
    end
  endtask

  task automatic issue_and_check(pe_req_t r, int unsigned lane);
    bit taken;
    send_req(r, lane, taken);
    if (taken) begin
      expected    = ref_model(r, lane);
      check_armed = 1'b1;
    end
    @(negedge clk);
    pe_req_valid = 1'b0;
    wait (!check_armed);
  endtask

  // A held request is accepted on the edge where ready comes back
  task automatic wait_accept_check(pe_req_t r, int unsigned lane);
    int n;
    n = 0;
    @(posedge clk);
    while (!pe_req_ready && n < MaxWait) begin
      n++;
      @(posedge clk);
    end
    if (!pe_req_ready) begin
      errors++;
      $display("Held request with id %0d was never accepted", r.id);
    end else begin
      expected    = ref_model(r, lane);
      check_armed = 1'b1;
      wait (!check_armed);
    end
  endtask

  task automatic check_blocked(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("pe_req_ready_o", 64'(pe_req_ready), 64'(0));
      check_value("vfu_operation_valid_o", 64'(vfu_op_valid), 64'(0));
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    $display("[%0d] %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "mismatches");
    err_mark = errors;
  endtask

  initial begin
    pe_req_t     r;
    bit          taken;
    int unsigned lane;

    void'($urandom(95));
    rst_n        = 1'b0;
    lane_id      = '0;
    pe_req       = '0;
    pe_req_valid = 1'b0;
    pe_running   = '1;
    opreq_ready  = '1;
    alu_ready    = 1'b1;
    alu_done_in  = '0;
    mfpu_ready   = 1'b1;
    mfpu_done_in = '0;
    expected     = '0;
    check_armed  = 1'b0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    err_mark     = 0;

    repeat (16) @(negedge clk);
    check_value("pe_req_ready_o", 64'(pe_req_ready), 64'(1));
    check_value("operand_request_valid_o", 64'(opreq_valid), 64'(0));
    check_value("vfu_operation_valid_o", 64'(vfu_op_valid), 64'(0));
    check_value("pe_resp_o.vinsn_done", 64'(pe_resp.vinsn_done), 64'(0));
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    lane = $urandom_range(0, NrLanes - 1);
    issue_and_check(rand_req(0, VADD, VFU_Alu, $urandom_range(NrLanes, 300)), lane);
    finish_test("alu vadd split");

    // On an empty lane the ALU op is skipped and reported done
    lane = $urandom_range(1, NrLanes - 1);
    issue_and_check(rand_req(1, VADD, VFU_Alu, $urandom_range(0, lane)), lane);
    finish_test("muted alu op");

    lane = $urandom_range(1, NrLanes - 1);
    issue_and_check(rand_req(2, VREDSUM, VFU_Alu, $urandom_range(0, lane)), lane);
    finish_test("reduction on empty lane");

    lane = $urandom_range(0, NrLanes - 1);
    r = rand_req(3, VFMACC, VFU_MFpu, $urandom_range(NrLanes, 300));
    issue_and_check(r, lane);
    // Swapped operands with vs2 unused and no mask operand
    r = rand_req(4, VFMACC, VFU_MFpu, $urandom_range(NrLanes, 300));
    r.swap_vs2_vd_op = 1'b1;
    r.use_vs2        = 1'b0;
    r.vm             = 1'b1;
    issue_and_check(r, lane);
    finish_test("fpu operand routing");

    lane = $urandom_range(0, NrLanes - 1);
    r = rand_req(5, VSE, VFU_StoreUnit, $urandom_range(1, 300));
    r.use_vs2   = 1'b0;
    r.use_vd_op = 1'b0;
    issue_and_check(r, lane);
    finish_test("unit-stride store");

    ////////////////////////////////////////////////
    // Back-pressure, done path and ID reuse
    ////////////////////////////////////////////////
    lane = $urandom_range(0, NrLanes - 1);
    @(negedge clk);
    opreq_ready = '0;
    issue_and_check(rand_req(6, VADD, VFU_Alu, $urandom_range(NrLanes, 300)), lane);
    r = rand_req(7, VADD, VFU_Alu, $urandom_range(NrLanes, 300));
    send_req(r, lane, taken);
    @(negedge clk);
    pe_req_valid = 1'b0;
    check_blocked(4);
    opreq_ready = '1;
    wait_accept_check(r, lane);

    @(negedge clk);
    alu_done_in = NrVInsn'(1) << 6;
    @(negedge clk);
    alu_done_in = '0;
    check_value("alu_vinsn_done_o", 64'(alu_done), 64'(1));
    check_value("mfpu_vinsn_done_o", 64'(mfpu_done), 64'(0));
    check_value("pe_resp_o.vinsn_done", 64'(pe_resp.vinsn_done), 64'(1) << 6);
    @(negedge clk);
    check_value("alu_vinsn_done_o", 64'(alu_done), 64'(0));
    mfpu_done_in = NrVInsn'(1) << 4;
    @(negedge clk);
    mfpu_done_in = '0;
    check_value("mfpu_vinsn_done_o", 64'(mfpu_done), 64'(1));
    check_value("alu_vinsn_done_o", 64'(alu_done), 64'(0));
    check_value("pe_resp_o.vinsn_done", 64'(pe_resp.vinsn_done), 64'(1) << 4);
    @(negedge clk);
    check_value("mfpu_vinsn_done_o", 64'(mfpu_done), 64'(0));

    // ID 6 is still live, so the repeat waits until the main sequencer drops it
    r = rand_req(6, VADD, VFU_Alu, $urandom_range(NrLanes, 300));
    send_req(r, lane, taken);
    @(negedge clk);
    pe_req_valid = 1'b0;
    check_blocked(3);
    pe_running = ~(NrVInsn'(1) << 6);
    wait_accept_check(r, lane);
    finish_test("back-pressure and id reuse");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(NumTests * 200 * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not finish", NumTests * 200);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/lane_seq_pkg.sv
hdl/pe_req_register.sv
hdl/lane_vl_split.sv
hdl/opreq_builder.sv
hdl/opreq_slots.sv
hdl/issue_ctrl.sv
hdl/insn_tracker.sv
hdl/lane_sequencer.sv
test/tb_lane_sequencer.sv

// File: run.sh
#!/bin/sh
# Build and run the lane sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_lane_sequencer -Mdir obj_dir

out=$(./obj_dir/Vtb_lane_sequencer)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
